// File: vlog.f
+incdir+verification
design/msg_format_pkg.sv
design/block_out_pkg.sv
design/msg_fetch_ctrl.sv
design/pad_word_former.sv
design/block_packer.sv
design/sha1_pad_top.sv
verification/sha1_pad_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module sha1_pad_tb \
    && ./obj_dir/Vsha1_pad_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "Result: FAIL"; exit 1; } \
    || { echo "Result: PASS"; exit 0; }

// File: verification/sha1_pad_model.svh
`ifndef SHA1_PAD_MODEL_SVH
`define SHA1_PAD_MODEL_SVH

// Blocks that a message of len bytes fills once padded
function automatic int expected_blocks(input int len);
    int blocks;
    blocks = len / 64 + 1;
    if (len % 64 >= 56) begin
        blocks = blocks + 1;  // No room left for the 64-bit length
    end
    return blocks;
endfunction

// One padded 512-bit block of the message whose bytes start at base in msg_bytes
function automatic logic [511:0] expected_block(input int base, input int len, input int blk);
    logic [511:0] block;
    logic [63:0]  bit_len;
    int           pos;
    int           j;
    block = '0;
    bit_len = 64'(len) << 3;
    for (j = 0; j < 64; j++) begin
        pos = blk * 64 + j;
        if (pos < len) begin
            block[511 - 8*j -: 8] = msg_bytes[base + pos];  // First byte sits in the top bits
        end else if (pos == len) begin
            block[511 - 8*j -: 8] = 8'h80;
        end
    end
    if (blk == expected_blocks(len) - 1) begin
        block[63:0] = bit_len;
    end
    return block;
endfunction

// Data FIFO word w of a message, sixteen bytes big-endian
function automatic logic [127:0] fifo_word(input int base, input int w);
    logic [127:0] data;
    int           k;
    data = '0;
    for (k = 0; k < 16; k++) begin
        data[127 - 8*k -: 8] = msg_bytes[base + 16*w + k];  // Bytes past the end are left as found
    end
    return data;
endfunction

`endif

// File: verification/sha1_pad_tb.sv
`timescale 1ns/10ps

module sha1_pad_tb;

    localparam int clk_period = 40;
    localparam int reset_cycles = 10;
    localparam int n_msgs = 24;
    localparam int byte_space = 8192;

    logic                                          sys_clk;
    logic                                          sys_rst;
    logic                                          msg_cal_channel_ready;
    logic                                          msg_info_fifo_empty;
    msg_format_pkg::msg_len_t                      msg_info;
    logic [block_out_pkg::chan_width-1:0]          msg_channel_num;
    logic                                          msg_info_rd_en;
    logic                                          msg_data_rd_en;
    logic [msg_format_pkg::msg_word_width-1:0]     msg_data;
    logic                                          msg_filled_data_valid;
    logic                                          msg_filled_data_sop;
    logic                                          msg_filled_data_eop;
    logic [block_out_pkg::block_width-1:0]         msg_filled_data;
    logic                                          msg_filled_info_valid;
    logic [block_out_pkg::info_width-1:0]          msg_filled_info;
    logic [block_out_pkg::tag_width-1:0]           msg_filled_tag;
    logic [block_out_pkg::addr_width-1:0]          msg_filled_addr;

    logic [7:0]    msg_bytes [0:byte_space-1];
    int            msg_len_q [n_msgs];
    int            msg_base [n_msgs];
    logic [5:0]    msg_chan [n_msgs];
    logic [21:0]   info_fifo [$];
    logic [127:0]  data_fifo [$];
    int            pending [$];
    logic [21:0]   info_word;
    logic [31:0]   rnd;
    integer        seed;
    bit            stim_built;
    logic          ready_q;
    logic          is_first;
    logic          is_last;
    int            watchdog_cycles;
    int            check_errors;
    int            other_errors;
    int            done_count;
    int            next_msg;
    int            blk_seen;
    int            cur;

    `include "sha1_pad_model.svh"

    sha1_pad_top i_sha1_pad_top (
        .sys_clk               (sys_clk),
        .sys_rst               (sys_rst),
        .msg_cal_channel_ready (msg_cal_channel_ready),
        .msg_info_fifo_empty   (msg_info_fifo_empty),
        .msg_info              (msg_info),
        .msg_channel_num       (msg_channel_num),
        .msg_info_rd_en        (msg_info_rd_en),
        .msg_data_rd_en        (msg_data_rd_en),
        .msg_data              (msg_data),
        .msg_filled_data_valid (msg_filled_data_valid),
        .msg_filled_data_sop   (msg_filled_data_sop),
        .msg_filled_data_eop   (msg_filled_data_eop),
        .msg_filled_data       (msg_filled_data),
        .msg_filled_info_valid (msg_filled_info_valid),
        .msg_filled_info       (msg_filled_info),
        .msg_filled_tag        (msg_filled_tag),
        .msg_filled_addr       (msg_filled_addr)
    );

    always #(clk_period / 2) sys_clk = ~sys_clk;

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    // Lays all messages back to back in msg_bytes and loads both FIFO queues
    task automatic build_messages();
        int fixed_len [7];
        int pos;
        int m;
        int w;
        fixed_len = '{0, 15, 16, 55, 56, 63, 64};
        pos = 0;
        watchdog_cycles = reset_cycles;
        for (m = 0; m < byte_space; m++) begin
            rnd = $random(seed);
            msg_bytes[m] = rnd[7:0];
        end
        for (m = 0; m < n_msgs; m++) begin
            rnd = $random(seed);
            msg_len_q[m] = (m < 7) ? fixed_len[m] : int'(rnd % 301);
            msg_chan[m] = rnd[29:24];
            msg_base[m] = pos;
            info_fifo.push_back({msg_chan[m], 16'(msg_len_q[m])});
            for (w = 0; w < (msg_len_q[m] + 15) / 16; w++) begin
                data_fifo.push_back(fifo_word(pos, w));
            end
            watchdog_cycles += (((msg_len_q[m] + 15) / 16) + 16) * 4;
            pos += msg_len_q[m];
        end
    endtask

    // Both FIFOs answer a read strobe with data in the following cycle
    always @(posedge sys_clk) begin
        if (msg_info_rd_en) begin
            if (info_fifo.size() == 0) begin
                $display("Info FIFO was read while empty at %0t", $time);
                other_errors++;
            end else begin
                info_word = info_fifo.pop_front();
                msg_info <= info_word[15:0];
                msg_channel_num <= info_word[21:16];
                pending.push_back(next_msg);
                next_msg++;
            end
        end
        if (msg_data_rd_en) begin
            if (data_fifo.size() == 0) begin
                $display("Data FIFO was read while empty at %0t", $time);
                other_errors++;
            end else begin
                msg_data <= data_fifo.pop_front();
            end
        end
        msg_info_fifo_empty <= (info_fifo.size() == 0);
        rnd = $random(seed);
        msg_cal_channel_ready <= (rnd[1:0] != 2'b00);  // Ready about three cycles in four
    end

    always @(posedge sys_clk) begin
        if (!sys_rst) begin
            if (msg_info_rd_en && !ready_q) begin
                $display("Info FIFO read at %0t although the channel was not ready", $time);
                other_errors++;
            end
            if (msg_filled_data_valid && pending.size() == 0) begin
                $display("Block output at %0t with no message pending", $time);
                other_errors++;
            end else if (msg_filled_data_valid) begin
                cur = pending[0];
                is_first = (blk_seen == 0);
                is_last = (blk_seen == expected_blocks(msg_len_q[cur]) - 1);
                check_value("msg_filled_data", msg_filled_data,
                            expected_block(msg_base[cur], msg_len_q[cur], blk_seen));
                check_value("msg_filled_data_sop", msg_filled_data_sop, is_first);
                check_value("msg_filled_data_eop", msg_filled_data_eop, is_last);
                check_value("msg_filled_info_valid", msg_filled_info_valid, is_first);
                check_value("msg_filled_addr", msg_filled_addr, {msg_chan[cur], blk_seen[5:0]});
                if (is_first) begin
                    check_value("msg_filled_info", msg_filled_info,
                                expected_blocks(msg_len_q[cur]));
                    check_value("msg_filled_tag", msg_filled_tag, cur[13:0]);
                end
                if (is_last) begin
                    void'(pending.pop_front());
                    blk_seen = 0;
                    done_count++;
                end else begin
                    blk_seen++;
                end
            end else begin
                check_value("msg_filled_data_sop", msg_filled_data_sop, 1'b0);
                check_value("msg_filled_data_eop", msg_filled_data_eop, 1'b0);
                check_value("msg_filled_info_valid", msg_filled_info_valid, 1'b0);
            end
        end
        ready_q <= msg_cal_channel_ready;
    end

    initial begin
        sys_clk = 1'b0;
        sys_rst = 1'b1;
        msg_cal_channel_ready = 1'b0;
        msg_info_fifo_empty = 1'b1;
        msg_info = '0;
        msg_channel_num = '0;
        msg_data = '0;
        ready_q = 1'b0;
        check_errors = 0;
        other_errors = 0;
        done_count = 0;
        next_msg = 0;
        blk_seen = 0;
        seed = 32'ha7ab_a86a;
        build_messages();
        stim_built = 1'b1;
        repeat (reset_cycles) @(posedge sys_clk);
        sys_rst <= 1'b0;
        wait (done_count == n_msgs);
        repeat (8) @(posedge sys_clk);  // Leaves room for a stray block to show up
        if (data_fifo.size() != 0) begin
            $display("%0d data words were never read", data_fifo.size());
            other_errors++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
        if (check_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (stim_built);
        #(watchdog_cycles * clk_period);
        $display("Timeout after %0d cycles with %0d of %0d messages done, %0d left pending",
                 watchdog_cycles, done_count, n_msgs, pending.size() + info_fifo.size());
        $display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: design/sha1_pad_top.sv
`timescale 1ns/10ps

module sha1_pad_top (
    input  logic                                         sys_clk,
    input  logic                                         sys_rst,
    input  logic                                         msg_cal_channel_ready,
    input  logic                                         msg_info_fifo_empty,
    input  msg_format_pkg::msg_len_t                     msg_info,
    input  logic [block_out_pkg::chan_width-1:0]         msg_channel_num,
    output logic                                         msg_info_rd_en,
    output logic                                         msg_data_rd_en,
    input  logic [msg_format_pkg::msg_word_width-1:0]    msg_data,
    output logic                                         msg_filled_data_valid,
    output logic                                         msg_filled_data_sop,
    output logic                                         msg_filled_data_eop,
    output logic [block_out_pkg::block_width-1:0]        msg_filled_data,
    output logic                                         msg_filled_info_valid,
    output logic [block_out_pkg::info_width-1:0]         msg_filled_info,
    output logic [block_out_pkg::tag_width-1:0]          msg_filled_tag,
    output logic [block_out_pkg::addr_width-1:0]         msg_filled_addr
);

    logic                                         msg_start;
    msg_format_pkg::msg_len_t                     msg_len;
    logic [block_out_pkg::chan_width-1:0]         chan;
    logic                                         word_valid;
    logic [msg_format_pkg::msg_word_width-1:0]    word;
    logic                                         busy;
    logic                                         pad_valid;
    logic                                         pad_first;
    logic                                         pad_last;
    logic [msg_format_pkg::msg_word_width-1:0]    pad_word;
    logic [block_out_pkg::block_cnt_width-1:0]    pad_blocks;
    logic [block_out_pkg::chan_width-1:0]         pad_chan;

    msg_fetch_ctrl i_msg_fetch_ctrl (
        .sys_clk               (sys_clk),
        .sys_rst               (sys_rst),
        .msg_cal_channel_ready (msg_cal_channel_ready),
        .msg_info_fifo_empty   (msg_info_fifo_empty),
        .msg_info              (msg_info),
        .msg_channel_num       (msg_channel_num),
        .msg_data              (msg_data),
        .busy                  (busy),
        .msg_info_rd_en        (msg_info_rd_en),
        .msg_data_rd_en        (msg_data_rd_en),
        .msg_start             (msg_start),
        .msg_len               (msg_len),
        .chan                  (chan),
        .word_valid            (word_valid),
        .word                  (word)
    );

    pad_word_former i_pad_word_former (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .msg_start  (msg_start),
        .msg_len    (msg_len),
        .chan       (chan),
        .word_valid (word_valid),
        .word       (word),
        .busy       (busy),
        .pad_valid  (pad_valid),
        .pad_first  (pad_first),
        .pad_last   (pad_last),
        .pad_word   (pad_word),
        .pad_blocks (pad_blocks),
        .pad_chan   (pad_chan)
    );

    block_packer i_block_packer (
        .sys_clk               (sys_clk),
        .sys_rst               (sys_rst),
        .pad_valid             (pad_valid),
        .pad_first             (pad_first),
        .pad_last              (pad_last),
        .pad_word              (pad_word),
        .pad_blocks            (pad_blocks),
        .pad_chan              (pad_chan),
        .msg_filled_data_valid (msg_filled_data_valid),
        .msg_filled_data_sop   (msg_filled_data_sop),
        .msg_filled_data_eop   (msg_filled_data_eop),
        .msg_filled_data       (msg_filled_data),
        .msg_filled_info_valid (msg_filled_info_valid),
        .msg_filled_info       (msg_filled_info),
        .msg_filled_tag        (msg_filled_tag),
        .msg_filled_addr       (msg_filled_addr)
    );

endmodule

// File: design/block_packer.sv
`timescale 1ns/10ps

module block_packer (
    input  logic                                         sys_clk,
    input  logic                                         sys_rst,
    input  logic                                         pad_valid,
    input  logic                                         pad_first,
    input  logic                                         pad_last,
    input  logic [msg_format_pkg::msg_word_width-1:0]    pad_word,
    input  logic [block_out_pkg::block_cnt_width-1:0]    pad_blocks,
    input  logic [block_out_pkg::chan_width-1:0]         pad_chan,
    output logic                                         msg_filled_data_valid,
    output logic                                         msg_filled_data_sop,
    output logic                                         msg_filled_data_eop,
    output logic [block_out_pkg::block_width-1:0]        msg_filled_data,
    output logic                                         msg_filled_info_valid,
    output logic [block_out_pkg::info_width-1:0]         msg_filled_info,
    output logic [block_out_pkg::tag_width-1:0]          msg_filled_tag,
    output logic [block_out_pkg::addr_width-1:0]         msg_filled_addr
);

    logic [block_out_pkg::block_width-msg_format_pkg::msg_word_width-1:0]  held;
    logic [$clog2(block_out_pkg::words_per_block)-1:0]                     word_sel;
    logic                                                                   first_held;
    logic [block_out_pkg::block_idx_width-1:0]                              blk_idx;
    logic [block_out_pkg::block_idx_width-1:0]                              cur_idx;
    logic                                                                   blk_done;

    assign blk_done = pad_valid && (word_sel == block_out_pkg::words_per_block - 1);
    assign cur_idx = first_held ? {block_out_pkg::block_idx_width{1'b0}} : blk_idx;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            word_sel <= '0;
            first_held <= 1'b0;
            blk_idx <= '0;
            msg_filled_data_valid <= 1'b0;
            msg_filled_data_sop <= 1'b0;
            msg_filled_data_eop <= 1'b0;
            msg_filled_info_valid <= 1'b0;
            msg_filled_tag <= '1;  // First message comes out as tag zero
        end else begin
            msg_filled_data_valid <= blk_done;
            msg_filled_data_sop <= blk_done && first_held;
            msg_filled_data_eop <= blk_done && pad_last;
            msg_filled_info_valid <= blk_done && first_held;
            if (pad_valid) begin
                word_sel <= word_sel + 1'b1;
                if (word_sel == '0) begin
                    first_held <= pad_first;  // A message always starts on a block boundary
                end
            end
            if (blk_done) begin
                blk_idx <= cur_idx + 1'b1;
                if (first_held) begin
                    msg_filled_tag <= msg_filled_tag + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pad_valid) begin
            held <= {held[block_out_pkg::block_width-2*msg_format_pkg::msg_word_width-1:0],
                     pad_word};
        end
        if (blk_done) begin
            msg_filled_data <= {held, pad_word};  // Oldest word sits in the top bits
            msg_filled_info <= {{(block_out_pkg::info_width-block_out_pkg::block_cnt_width){1'b0}},
                                pad_blocks};
            msg_filled_addr <= {pad_chan, cur_idx};
        end
    end

endmodule

// File: design/pad_word_former.sv
`timescale 1ns/10ps

module pad_word_former (
    input  logic                                         sys_clk,
    input  logic                                         sys_rst,
    input  logic                                         msg_start,
    input  msg_format_pkg::msg_len_t                     msg_len,
    input  logic [block_out_pkg::chan_width-1:0]         chan,
    input  logic                                         word_valid,
    input  logic [msg_format_pkg::msg_word_width-1:0]    word,
    output logic                                         busy,
    output logic                                         pad_valid,
    output logic                                         pad_first,
    output logic                                         pad_last,
    output logic [msg_format_pkg::msg_word_width-1:0]    pad_word,
    output logic [block_out_pkg::block_cnt_width-1:0]    pad_blocks,
    output logic [block_out_pkg::chan_width-1:0]         pad_chan
);

    logic                                          active;
    msg_format_pkg::msg_len_t                      len_q;
    logic [msg_format_pkg::word_idx_width-1:0]     idx;
    logic [msg_format_pkg::word_idx_width-1:0]     data_words;
    logic [msg_format_pkg::word_idx_width-1:0]     pad_pos;
    logic [msg_format_pkg::word_idx_width-1:0]     last_idx;
    logic [block_out_pkg::block_cnt_width-1:0]     blocks;
    logic [msg_format_pkg::len_field_width-1:0]    bit_len;
    logic [msg_format_pkg::msg_word_width-1:0]     keep_mask;
    logic [msg_format_pkg::msg_word_width-1:0]     pad_bits;
    logic [msg_format_pkg::msg_word_width-1:0]     next_word;
    logic                                          step;

    // One extra block when the pad byte lands past the length field boundary
    assign blocks = {1'b0, msg_len.blocks.block_cnt}
                  + ((msg_len.blocks.block_off >= msg_format_pkg::len_limit_bytes) ? 11'd2 : 11'd1);

    assign pad_pos = {1'b0, len_q.words.word_cnt};  // Word that carries the pad byte
    assign last_idx = {pad_blocks, 2'b00} - 1'b1;
    assign bit_len = {{(msg_format_pkg::len_field_width - msg_format_pkg::msg_len_width - 3){1'b0}},
                      len_q, 3'b000};

    // Data words wait for the fetch stage, fill words go out every cycle
    assign step = active && (word_valid || (idx >= data_words));
    assign busy = active || msg_start || pad_last;

    always_comb begin
        keep_mask = ~({msg_format_pkg::msg_word_width{1'b1}} >> {len_q.words.tail_bytes, 3'b000});
        pad_bits = {msg_format_pkg::pad_byte, {(msg_format_pkg::msg_word_width-8){1'b0}}}
                   >> {len_q.words.tail_bytes, 3'b000};
        if (idx < pad_pos) begin
            next_word = word;
        end else if (idx == pad_pos) begin
            next_word = (word & keep_mask) | pad_bits;  // Mask is all zero for an empty tail
        end else begin
            next_word = '0;
        end
        if (idx == last_idx) begin
            next_word[msg_format_pkg::len_field_width-1:0] =
                next_word[msg_format_pkg::len_field_width-1:0] | bit_len;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            active <= 1'b0;
            idx <= '0;
            pad_valid <= 1'b0;
            pad_first <= 1'b0;
            pad_last <= 1'b0;
        end else begin
            pad_valid <= step;
            pad_first <= step && (idx == '0);
            pad_last <= step && (idx == last_idx);
            if (msg_start) begin
                active <= 1'b1;
                idx <= '0;
            end else if (step) begin
                idx <= idx + 1'b1;
                if (idx == last_idx) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (msg_start) begin
            len_q <= msg_len;
            pad_chan <= chan;
            pad_blocks <= blocks;
            data_words <= msg_format_pkg::word_count(msg_len);
        end
        if (step) begin
            pad_word <= next_word;
        end
    end

endmodule

// File: design/msg_fetch_ctrl.sv
`timescale 1ns/10ps

module msg_fetch_ctrl (
    input  logic                                        sys_clk,
    input  logic                                        sys_rst,
    input  logic                                        msg_cal_channel_ready,
    input  logic                                        msg_info_fifo_empty,
    input  msg_format_pkg::msg_len_t                    msg_info,
    input  logic [block_out_pkg::chan_width-1:0]        msg_channel_num,
    input  logic [msg_format_pkg::msg_word_width-1:0]   msg_data,
    input  logic                                        busy,
    output logic                                        msg_info_rd_en,
    output logic                                        msg_data_rd_en,
    output logic                                        msg_start,
    output msg_format_pkg::msg_len_t                    msg_len,
    output logic [block_out_pkg::chan_width-1:0]        chan,
    output logic                                        word_valid,
    output logic [msg_format_pkg::msg_word_width-1:0]   word
);

    logic [1:0]                                  state;
    logic [msg_format_pkg::word_idx_width-1:0]   rd_cnt;
    logic [msg_format_pkg::word_idx_width-1:0]   n_words;
    logic                                        info_here;
    logic                                        data_due;

    // The strobe has dropped, so the info FIFO outputs hold this message
    assign info_here = (state == msg_format_pkg::fetch_info_wait) && !msg_info_rd_en;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state <= msg_format_pkg::fetch_idle;
            msg_info_rd_en <= 1'b0;
            msg_data_rd_en <= 1'b0;
            msg_start <= 1'b0;
            rd_cnt <= '0;
        end else begin
            msg_info_rd_en <= 1'b0;
            msg_start <= 1'b0;
            case (state)
                msg_format_pkg::fetch_idle: begin
                    if (!busy && !msg_info_fifo_empty && msg_cal_channel_ready) begin
                        msg_info_rd_en <= 1'b1;
                        state <= msg_format_pkg::fetch_info_wait;
                    end
                end
                msg_format_pkg::fetch_info_wait: begin
                    if (info_here) begin
                        msg_start <= 1'b1;
                        rd_cnt <= {{(msg_format_pkg::word_idx_width-1){1'b0}}, 1'b1};
                        if (msg_format_pkg::word_count(msg_info) != '0) begin
                            msg_data_rd_en <= 1'b1;
                            state <= msg_format_pkg::fetch_burst;
                        end else begin
                            state <= msg_format_pkg::fetch_idle;  // Empty body needs no reads
                        end
                    end
                end
                msg_format_pkg::fetch_burst: begin
                    if (rd_cnt == n_words) begin
                        msg_data_rd_en <= 1'b0;
                        state <= msg_format_pkg::fetch_idle;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                default: state <= msg_format_pkg::fetch_idle;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (info_here) begin
            msg_len <= msg_info;
            chan <= msg_channel_num;
            n_words <= msg_format_pkg::word_count(msg_info);
        end
    end

    // Data returns one cycle after its strobe and is registered once more
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            data_due <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            data_due <= msg_data_rd_en;
            word_valid <= data_due;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (data_due) begin
            word <= msg_data;
        end
    end

endmodule

// File: design/block_out_pkg.sv
package block_out_pkg;

    localparam int block_width = 512;
    localparam int words_per_block = 4;
    localparam int block_cnt_width = 11;
    localparam int tag_width = 14;
    localparam int chan_width = 6;
    localparam int block_idx_width = 6;
    localparam int addr_width = chan_width + block_idx_width;  // Channel above block index
    localparam int info_width = 16;

endpackage

// File: design/msg_format_pkg.sv
package msg_format_pkg;

    localparam int msg_word_width = 128;
    localparam int msg_len_width = 16;
    localparam int word_bytes = 16;
    localparam int word_idx_width = msg_len_width - $clog2(word_bytes) + 1;  // Counts up to 4096 words
    localparam logic [7:0] pad_byte = 8'h80;
    localparam int len_field_width = 64;
    localparam int len_limit_bytes = 56;  // Offsets from here on leave no room for the length

    localparam logic [1:0] fetch_idle = 2'd0;
    localparam logic [1:0] fetch_info_wait = 2'd1;
    localparam logic [1:0] fetch_burst = 2'd2;

    // The byte count seen as 16-byte words plus tail, or as 64-byte blocks plus offset
    typedef union packed {
        struct packed {
            logic [msg_len_width-$clog2(word_bytes)-1:0] word_cnt;
            logic [$clog2(word_bytes)-1:0]               tail_bytes;
        } words;
        struct packed {
            logic [9:0] block_cnt;
            logic [5:0] block_off;
        } blocks;
    } msg_len_t;

    // Number of message words that carry data bytes
    function automatic logic [word_idx_width-1:0] word_count(msg_len_t len);
        return {1'b0, len.words.word_cnt} + {{(word_idx_width-1){1'b0}}, |len.words.tail_bytes};
    endfunction

endpackage
